// ==== logic/dsp_cfg_pkg.sv ====
package dsp_cfg_pkg;

   // settings bus map of the receive core
   localparam logic [7:0] rx_base_addr = 8'd160;

   localparam logic [7:0] reg_phase_inc = 8'd0;   // nco increment, 32 bits
   localparam logic [7:0] reg_scale = 8'd1;       // scale_i [31:16], scale_q [15:0]
   localparam logic [7:0] reg_decim = 8'd2;       // log2 of cic rate
   localparam logic [7:0] reg_ofs_a = 8'd6;       // dc offset of channel a
   localparam logic [7:0] reg_ofs_b = 8'd7;       // dc offset of channel b
   localparam logic [7:0] reg_mux = 8'd8;         // i source [1:0], q source [3:2]

   // code 0 picks input b, kept from the board wiring
   typedef enum logic [1:0] {
      src_chan_b = 2'd0,
      src_chan_a = 2'd1,
      src_zero = 2'd2
   } iq_src_e;

   typedef struct packed {
      logic [31:0] phase_inc;
      logic signed [15:0] scale_i;   // q1.15
      logic signed [15:0] scale_q;   // q1.15
      logic [2:0] decim_log2;        // 0 to 6
      logic signed [13:0] ofs_a;
      logic signed [13:0] ofs_b;
      iq_src_e src_i;
      iq_src_e src_q;
   } rx_config_t;

endpackage

// ==== logic/dsp_sample_pkg.sv ====
package dsp_sample_pkg;

   localparam int adc_width = 14;
   localparam int dsp_width = 24;
   localparam int out_width = 16;

   typedef struct packed {
      logic signed [dsp_width-1:0] i;
      logic signed [dsp_width-1:0] q;
   } iq_dsp_t;

   typedef struct packed {
      logic signed [out_width-1:0] i;   // upper half of the word
      logic signed [out_width-1:0] q;
   } iq_out_t;

   // atan(2^-k) with a full turn of 2^24
   function automatic logic [23:0] cordic_atan(input int k);
      logic [23:0] a;
      case (k)
         0: a = 24'd2097152;
         1: a = 24'd1238021;
         2: a = 24'd654136;
         3: a = 24'd332050;
         4: a = 24'd166669;
         5: a = 24'd83416;
         6: a = 24'd41718;
         7: a = 24'd20860;
         8: a = 24'd10430;
         9: a = 24'd5215;
         10: a = 24'd2608;
         11: a = 24'd1304;
         12: a = 24'd652;
         13: a = 24'd326;
         14: a = 24'd163;
         15: a = 24'd81;
         16: a = 24'd41;
         17: a = 24'd20;
         18: a = 24'd10;
         19: a = 24'd5;
         20: a = 24'd3;
         21: a = 24'd1;
         22: a = 24'd1;
         default: a = 24'd0;
      endcase
      return a;
   endfunction

endpackage

// ==== logic/rx_settings.sv ====
`timescale 1ns/100ps

module rx_settings (
   input  logic clk,
   input  logic rst,
   input  logic set_stb,
   input  logic [7:0] set_addr,
   input  logic [31:0] set_data,
   output dsp_cfg_pkg::rx_config_t cfg
);
   import dsp_cfg_pkg::*;

   always_ff @(posedge clk) begin
      if (rst) begin
         cfg <= '0;
      end else if (set_stb) begin
         case (set_addr)
            rx_base_addr + reg_phase_inc: begin
               cfg.phase_inc <= set_data;
            end
            rx_base_addr + reg_scale: begin
               cfg.scale_i <= set_data[31:16];
               cfg.scale_q <= set_data[15:0];
            end
            rx_base_addr + reg_decim: begin
               cfg.decim_log2 <= set_data[2:0];   // rate is 2^decim_log2
            end
            rx_base_addr + reg_ofs_a: begin
               cfg.ofs_a <= set_data[13:0];
            end
            rx_base_addr + reg_ofs_b: begin
               cfg.ofs_b <= set_data[13:0];
            end
            rx_base_addr + reg_mux: begin
               cfg.src_i <= iq_src_e'(set_data[1:0]);
               cfg.src_q <= iq_src_e'(set_data[3:2]);
            end
            default: begin
               // not one of ours, another block may own it
            end
         endcase
      end
   end

endmodule

// ==== logic/rx_frontend.sv ====
`timescale 1ns/100ps

module rx_frontend (
   input  logic clk,
   input  logic rst,
   input  logic run,
   input  dsp_cfg_pkg::rx_config_t cfg,
   input  logic [13:0] adc_a,
   input  logic [13:0] adc_b,
   output dsp_sample_pkg::iq_dsp_t scaled,
   output logic [23:0] phase
);
   import dsp_cfg_pkg::*;
   import dsp_sample_pkg::*;

   localparam int pw = adc_width + 16;   // product bits
   localparam int gain_shift = 7;        // headroom for cordic gain

   logic signed [adc_width:0] diff_a;
   logic signed [adc_width:0] diff_b;
   logic signed [adc_width-1:0] ofs_a_q;
   logic signed [adc_width-1:0] ofs_b_q;
   logic signed [adc_width-1:0] mux_i;
   logic signed [adc_width-1:0] mux_q;
   logic signed [pw-1:0] prod_i;
   logic signed [pw-1:0] prod_q;
   logic [31:0] phase_acc;

   function automatic logic signed [adc_width-1:0] sat_adc(
      input logic signed [adc_width:0] v
   );
      logic signed [adc_width-1:0] r;
      if (v[adc_width] != v[adc_width-1]) begin
         r = v[adc_width] ? {1'b1, {(adc_width-1){1'b0}}} : {1'b0, {(adc_width-1){1'b1}}};
      end else begin
         r = v[adc_width-1:0];
      end
      return r;
   endfunction

   function automatic logic signed [adc_width-1:0] pick(
      input iq_src_e src,
      input logic signed [adc_width-1:0] a,
      input logic signed [adc_width-1:0] b
   );
      logic signed [adc_width-1:0] r;
      case (src)
         src_chan_b: r = b;
         src_chan_a: r = a;
         default: r = '0;   // src_zero and code 3
      endcase
      return r;
   endfunction

   assign diff_a = {adc_a[adc_width-1], adc_a} - {cfg.ofs_a[adc_width-1], cfg.ofs_a};
   assign diff_b = {adc_b[adc_width-1], adc_b} - {cfg.ofs_b[adc_width-1], cfg.ofs_b};

   assign prod_i = mux_i * $signed(cfg.scale_i);
   assign prod_q = mux_q * $signed(cfg.scale_q);

   always_ff @(posedge clk) begin
      ofs_a_q <= sat_adc(diff_a);   // stage 1
      ofs_b_q <= sat_adc(diff_b);
      mux_i <= pick(cfg.src_i, ofs_a_q, ofs_b_q);   // stage 2
      mux_q <= pick(cfg.src_q, ofs_a_q, ofs_b_q);
      scaled.i <= {{(dsp_width - pw + gain_shift){prod_i[pw-1]}}, prod_i[pw-1:gain_shift]};
      scaled.q <= {{(dsp_width - pw + gain_shift){prod_q[pw-1]}}, prod_q[pw-1:gain_shift]};
   end

   // nco, held at zero phase while stopped
   always_ff @(posedge clk) begin
      if (rst || !run) begin
         phase_acc <= '0;
      end else begin
         phase_acc <= phase_acc + cfg.phase_inc;
      end
   end

   assign phase = phase_acc[31:8];

endmodule

// ==== logic/cordic_rotator.sv ====
`timescale 1ns/100ps

module cordic_rotator #(
   parameter int cordic_stages = 16
) (
   input  logic clk,
   input  logic rst,
   input  dsp_sample_pkg::iq_dsp_t in,
   input  logic [23:0] phase,
   output dsp_sample_pkg::iq_dsp_t out
);
   import dsp_sample_pkg::*;

   localparam int zw = 24;   // phase bits, full turn is 2^24
   localparam logic [zw-1:0] half_turn = 24'h800000;

   logic signed [dsp_width-1:0] x [0:cordic_stages];
   logic signed [dsp_width-1:0] y [0:cordic_stages];
   logic signed [zw-1:0] z [0:cordic_stages];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int k = 0; k <= cordic_stages; k++) begin
            x[k] <= '0;
            y[k] <= '0;
            z[k] <= '0;
         end
      end else begin
         // fold quadrants 2 and 3 back into +-90 degrees
         case (phase[zw-1:zw-2])
            2'b01, 2'b10: begin
               x[0] <= -in.i;
               y[0] <= -in.q;
               z[0] <= phase + half_turn;
            end
            default: begin
               x[0] <= in.i;
               y[0] <= in.q;
               z[0] <= phase;
            end
         endcase

         for (int k = 0; k < cordic_stages; k++) begin
            if (!z[k][zw-1]) begin   // residual positive, rotate ccw
               x[k+1] <= x[k] - (y[k] >>> k);
               y[k+1] <= y[k] + (x[k] >>> k);
               z[k+1] <= z[k] - cordic_atan(k);
            end else begin
               x[k+1] <= x[k] + (y[k] >>> k);
               y[k+1] <= y[k] - (x[k] >>> k);
               z[k+1] <= z[k] + cordic_atan(k);
            end
         end
      end
   end

   // output still carries the ~1.647 cordic gain
   assign out.i = x[cordic_stages];
   assign out.q = y[cordic_stages];

endmodule

// ==== logic/cic_decimator.sv ====
`timescale 1ns/100ps

module cic_decimator #(
   parameter int cic_max_log2 = 6
) (
   input  logic clk,
   input  logic rst,
   input  logic run,
   input  logic [2:0] decim_log2,
   input  dsp_sample_pkg::iq_dsp_t in,
   output dsp_sample_pkg::iq_out_t sample,
   output logic strobe
);
   import dsp_sample_pkg::*;

   localparam int aw = dsp_width + 2 * cic_max_log2;   // room for rate^2 growth
   localparam int drop = dsp_width - out_width;
   localparam logic signed [dsp_width:0] half_lsb = 1 << (drop - 1);

   logic [cic_max_log2:0] rate_m1;
   logic [cic_max_log2-1:0] cnt;
   logic tick;
   logic signed [dsp_width-1:0] chan [2];   // 0 is i, 1 is q
   logic signed [aw-1:0] integ1 [2];
   logic signed [aw-1:0] integ2 [2];
   logic signed [aw-1:0] dly1 [2];
   logic signed [aw-1:0] dly2 [2];
   logic signed [aw-1:0] comb1 [2];
   logic signed [aw-1:0] comb2 [2];
   logic signed [aw-1:0] shifted [2];
   logic signed [out_width-1:0] rounded [2];

   // half lsb added, so ties go up; then clamp to out_width
   function automatic logic signed [out_width-1:0] round_sat(
      input logic signed [dsp_width-1:0] v
   );
      logic signed [dsp_width:0] sum;
      logic [out_width:0] top;
      logic signed [out_width-1:0] r;
      sum = {v[dsp_width-1], v} + half_lsb;
      top = sum[dsp_width:drop];
      if (top[out_width] != top[out_width-1]) begin
         r = top[out_width] ? {1'b1, {(out_width-1){1'b0}}} : {1'b0, {(out_width-1){1'b1}}};
      end else begin
         r = top[out_width-1:0];
      end
      return r;
   endfunction

   assign rate_m1 = ({{cic_max_log2{1'b0}}, 1'b1} << decim_log2) - 1'b1;
   assign tick = run && ({1'b0, cnt} == rate_m1);

   always_comb begin
      chan[0] = in.i;
      chan[1] = in.q;
      for (int c = 0; c < 2; c++) begin
         comb1[c] = integ2[c] - dly1[c];
         comb2[c] = comb1[c] - dly2[c];
         shifted[c] = comb2[c] >>> {decim_log2, 1'b0};   // divide by rate^2
         rounded[c] = round_sat(shifted[c][dsp_width-1:0]);
      end
   end

   always_ff @(posedge clk) begin
      if (rst || !run) begin
         cnt <= '0;
         for (int c = 0; c < 2; c++) begin
            integ1[c] <= '0;
            integ2[c] <= '0;
            dly1[c] <= '0;
            dly2[c] <= '0;
         end
      end else begin
         cnt <= tick ? '0 : cnt + 1'b1;
         for (int c = 0; c < 2; c++) begin
            integ1[c] <= integ1[c] + {{(aw-dsp_width){chan[c][dsp_width-1]}}, chan[c]};
            integ2[c] <= integ2[c] + integ1[c];
            if (tick) begin   // combs run at the low rate
               dly1[c] <= integ2[c];
               dly2[c] <= comb1[c];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         sample <= '0;
         strobe <= 1'b0;
      end else begin
         strobe <= tick;
         if (tick) begin
            sample.i <= rounded[0];
            sample.q <= rounded[1];
         end
      end
   end

endmodule

// ==== logic/dsp_rx_core.sv ====
`timescale 1ns/100ps

module dsp_rx_core #(
   parameter int cordic_stages = 16,
   parameter int cic_max_log2 = 6
) (
   input  logic clk,
   input  logic rst,
   input  logic run,
   input  logic set_stb,
   input  logic [7:0] set_addr,
   input  logic [31:0] set_data,
   input  logic [13:0] adc_a,
   input  logic [13:0] adc_b,
   output dsp_sample_pkg::iq_out_t sample,
   output logic strobe
);
   import dsp_cfg_pkg::*;
   import dsp_sample_pkg::*;

   rx_config_t cfg;
   iq_dsp_t scaled;    // after gain, 3 cycles in
   iq_dsp_t rotated;   // after cordic
   logic [23:0] phase;

   rx_settings u_settings (
      .clk      (clk),
      .rst      (rst),
      .set_stb  (set_stb),
      .set_addr (set_addr),
      .set_data (set_data),
      .cfg      (cfg)
   );

   rx_frontend u_frontend (
      .clk    (clk),
      .rst    (rst),
      .run    (run),
      .cfg    (cfg),
      .adc_a  (adc_a),
      .adc_b  (adc_b),
      .scaled (scaled),
      .phase  (phase)
   );

   cordic_rotator #(
      .cordic_stages (cordic_stages)
   ) u_cordic (
      .clk   (clk),
      .rst   (rst),
      .in    (scaled),
      .phase (phase),
      .out   (rotated)
   );

   cic_decimator #(
      .cic_max_log2 (cic_max_log2)
   ) u_cic (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .decim_log2 (cfg.decim_log2),
      .in         (rotated),
      .sample     (sample),
      .strobe     (strobe)
   );

endmodule

// ==== verif/dsp_rx_core_tb.sv ====
`timescale 1ns/100ps

module dsp_rx_core_tb;
   import dsp_cfg_pkg::*;
   import dsp_sample_pkg::*;

   localparam int cordic_stages = 16;
   localparam int cic_max_log2 = 6;
   localparam int timeout_cycles = 5000;

   logic clk;
   logic rst;
   logic run;
   logic set_stb;
   logic [7:0] set_addr;
   logic [31:0] set_data;
   logic [13:0] adc_a;
   logic [13:0] adc_b;
   iq_out_t sample;
   logic strobe;

   rx_config_t shadow;   // configuration the dut should hold
   string test_name;
   iq_out_t expected;
   int check_tol;
   int skip_count;
   logic check_en;
   int seen;
   int strobe_count;
   int checks;
   int errors;
   int tests;
   integer seed;

   dsp_rx_core #(
      .cordic_stages (cordic_stages),
      .cic_max_log2  (cic_max_log2)
   ) uut (
      .clk      (clk),
      .rst      (rst),
      .run      (run),
      .set_stb  (set_stb),
      .set_addr (set_addr),
      .set_data (set_data),
      .adc_a    (adc_a),
      .adc_b    (adc_b),
      .sample   (sample),
      .strobe   (strobe)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic int clamp(input int v, input int lo, input int hi);
      return (v < lo) ? lo : ((v > hi) ? hi : v);
   endfunction

   function automatic int route(input iq_src_e s, input int a, input int b);
      return (s == src_chan_b) ? b : ((s == src_chan_a) ? a : 0);
   endfunction

   // expected output for constant adc input at zero nco phase once the cic has settled
   function automatic iq_out_t model_sample(input rx_config_t c, input logic [13:0] a_in,
                                            input logic [13:0] b_in);
      int da;
      int db;
      int p;
      int r;
      logic signed [23:0] x;
      logic signed [23:0] y;
      logic signed [23:0] z;
      logic signed [23:0] xn;
      iq_out_t res;
      da = clamp(int'($signed(a_in)) - int'(c.ofs_a), -8192, 8191);
      db = clamp(int'($signed(b_in)) - int'(c.ofs_b), -8192, 8191);
      p = route(c.src_i, da, db) * int'(c.scale_i);
      x = 24'(p >>> 7);
      p = route(c.src_q, da, db) * int'(c.scale_q);
      y = 24'(p >>> 7);
      z = '0;   // zero phase needs no pre-rotation
      for (int k = 0; k < cordic_stages; k++) begin
         xn = z[23] ? x + (y >>> k) : x - (y >>> k);
         y = z[23] ? y - (x >>> k) : y + (x >>> k);
         z = z[23] ? z + cordic_atan(k) : z - cordic_atan(k);
         x = xn;
      end
      // cic gain divides out exactly before the round half up to 16 bits
      r = clamp((int'(x) + 128) >>> 8, -32768, 32767);
      res.i = 16'(r);
      r = clamp((int'(y) + 128) >>> 8, -32768, 32767);
      res.q = 16'(r);
      return res;
   endfunction

   task automatic check_sample(input string name, input iq_out_t exp, input iq_out_t act,
                               input int tol);
      int di;
      int dq;
      di = int'(act.i) - int'(exp.i);
      dq = int'(act.q) - int'(exp.q);
      checks++;
      if (di < -tol || di > tol || dq < -tol || dq > tol) begin
         errors++;
         $display("[ERROR] %s: expected i=%0d q=%0d, actual i=%0d q=%0d",
                  name, exp.i, exp.q, act.i, act.q);
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act, input int tol);
      checks++;
      if (act < exp - tol || act > exp + tol) begin
         errors++;
         $display("[ERROR] %s: expected %0d strobes, actual %0d", name, exp, act);
      end
   endtask

   // registered outputs hold their value across the rising edge
   always @(posedge clk) begin
      if (strobe) begin
         strobe_count = strobe_count + 1;
         if (check_en) begin
            seen = seen + 1;
            if (seen > skip_count) begin
               check_sample(test_name, expected, sample, check_tol);
            end
         end
      end
   end

   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set_stb = 1'b1;
      set_addr = addr;
      set_data = data;
      @(negedge clk);
      set_stb = 1'b0;
   endtask

   task automatic set_reg(input logic [7:0] offset, input logic [31:0] data);
      case (offset)
         reg_phase_inc: shadow.phase_inc = data;
         reg_scale: begin
            shadow.scale_i = data[31:16];
            shadow.scale_q = data[15:0];
         end
         reg_decim: shadow.decim_log2 = data[2:0];
         reg_ofs_a: shadow.ofs_a = data[13:0];
         reg_ofs_b: shadow.ofs_b = data[13:0];
         reg_mux: begin
            shadow.src_i = iq_src_e'(data[1:0]);
            shadow.src_q = iq_src_e'(data[3:2]);
         end
         default: ;
      endcase
      write_setting(rx_base_addr + offset, data);
   endtask

   task automatic report_test(input string name, input int err0);
      tests++;
      if (errors == err0) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - err0);
      end
   endtask

   task automatic wait_checked(input int n);
      int cycles;
      cycles = 0;
      while (seen < skip_count + n && cycles < timeout_cycles) begin
         @(negedge clk);
         cycles++;
      end
      if (seen < skip_count + n) begin
         errors++;
         $display("timeout in %s, got %0d of %0d strobes", test_name, seen, skip_count + n);
      end
   endtask

   task automatic run_checked(input string name, input iq_out_t exp, input int skip_n,
                              input int tol, input int n);
      int err0;
      err0 = errors;
      run = 1'b0;
      repeat (30) @(negedge clk);   // fill front end and cordic
      test_name = name;
      expected = exp;
      skip_count = skip_n;
      check_tol = tol;
      seen = 0;
      check_en = 1'b1;
      run = 1'b1;
      wait_checked(n);
      check_en = 1'b0;
      run = 1'b0;
      report_test(name, err0);
   endtask

   task automatic rate_test(input logic [2:0] d);
      int c0;
      int err0;
      err0 = errors;
      set_reg(reg_decim, {29'd0, d});
      c0 = strobe_count;
      run = 1'b1;
      repeat (256) @(negedge clk);
      run = 1'b0;
      check_count($sformatf("strobe rate %0d", 1 << d), 256 >> d, strobe_count - c0, 1);
      report_test($sformatf("strobe rate %0d", 1 << d), err0);
   endtask

   task automatic random_const(input logic [2:0] d);
      adc_a = 14'($random(seed));
      adc_b = 14'($random(seed));
      set_reg(reg_ofs_a, 32'($random(seed) % 2048));
      set_reg(reg_ofs_b, 32'($random(seed) % 2048));
      set_reg(reg_scale, 32'($random(seed)));
      set_reg(reg_mux, {28'd0, src_chan_b, src_chan_a});   // i from a and q from b
      set_reg(reg_decim, {29'd0, d});
      set_reg(reg_phase_inc, 32'd0);
   endtask

   initial begin
      iq_src_e mux_i [6];
      iq_src_e mux_q [6];
      iq_out_t exp;
      int c0;
      int err0;
      rst = 1'b1;
      run = 1'b0;
      set_stb = 1'b0;
      set_addr = '0;
      set_data = '0;
      adc_a = '0;
      adc_b = '0;
      shadow = '0;
      test_name = "";
      expected = '0;
      check_tol = 0;
      skip_count = 0;
      check_en = 1'b0;
      seen = 0;
      strobe_count = 0;
      checks = 0;
      errors = 0;
      tests = 0;
      seed = 32'hd55d;
      mux_i = '{src_chan_a, src_chan_a, src_chan_b, src_chan_b, src_zero, src_chan_b};
      mux_q = '{src_chan_a, src_chan_b, src_chan_a, src_chan_b, src_chan_a, src_zero};
      repeat (5) @(negedge clk);
      rst = 1'b0;

      rate_test(3'd0);
      rate_test(3'd2);
      rate_test(3'd6);
      err0 = errors;
      run = 1'b0;
      repeat (3) @(negedge clk);   // drain a late strobe
      c0 = strobe_count;
      repeat (200) @(negedge clk);
      check_count("run low", 0, strobe_count - c0, 0);
      report_test("run low", err0);

      for (int r = 0; r < 3; r++) begin
         random_const(3'd0);
         run_checked($sformatf("constant rate 1 #%0d", r),
                     model_sample(shadow, adc_a, adc_b), 2, 0, 6);
         random_const(3'd4);
         run_checked($sformatf("constant rate 16 #%0d", r),
                     model_sample(shadow, adc_a, adc_b), 2, 0, 4);
      end

      random_const(3'd1);
      for (int m = 0; m < 6; m++) begin
         set_reg(reg_mux, {28'd0, mux_q[m], mux_i[m]});
         run_checked($sformatf("mux i=%0d q=%0d", mux_i[m], mux_q[m]),
                     model_sample(shadow, adc_a, adc_b), 2, 0, 4);
      end
      set_reg(reg_mux, {28'd0, src_zero, src_zero});
      run_checked("mux zero", '0, 2, 0, 4);

      set_reg(reg_mux, {28'd0, src_chan_b, src_chan_a});
      adc_a = 14'd3000;
      set_reg(reg_ofs_a, 32'd3000);
      exp = model_sample(shadow, adc_a, adc_b);
      exp.i = '0;   // offset cancels channel a exactly
      run_checked("offset cancels", exp, 2, 0, 4);
      adc_a = 14'(-8000);
      set_reg(reg_ofs_a, 32'd5000);
      run_checked("offset saturates low", model_sample(shadow, adc_a, adc_b), 2, 0, 4);
      adc_a = 14'd8000;
      set_reg(reg_ofs_a, 32'(-5000));
      run_checked("offset saturates high", model_sample(shadow, adc_a, adc_b), 2, 0, 4);

      // four quarter-turn rotations cancel in each output
      random_const(3'd2);
      set_reg(reg_phase_inc, 32'h4000_0000);
      run_checked("nco rotation", '0, 8, 2, 6);
      set_reg(reg_phase_inc, 32'd0);

      random_const(3'd1);
      exp = model_sample(shadow, adc_a, adc_b);
      write_setting(8'd170, 32'($random(seed)));
      run_checked("wrong address", exp, 2, 0, 4);

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// ==== filelist.f ====
logic/dsp_cfg_pkg.sv
logic/dsp_sample_pkg.sv
logic/rx_settings.sv
logic/rx_frontend.sv
logic/cordic_rotator.sv
logic/cic_decimator.sv
logic/dsp_rx_core.sv
verif/dsp_rx_core_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := dsp_rx_core_tb
FILELIST  := filelist.f
VFLAGS    := --binary --timescale 1ns/100ps -Wno-fatal
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
